/* sources.f */
logic/alu_pkg.sv
logic/alu_ifs.sv
logic/control_decode.sv
logic/alu.sv
logic/reg_writeback.sv
logic/alu_datapath.sv
verification/alu_datapath_asserts.sv
verification/alu_datapath_tb.sv

/* verification/alu_datapath_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module alu_datapath_tb;

    // one instruction and the state it should leave behind once written back
    typedef struct packed {
        alu_pkg::alu_op_t  op;
        alu_pkg::reg_sel_t x_sel;
        alu_pkg::reg_sel_t y_sel;
        alu_pkg::reg_sel_t dst_sel;
        logic              use_imm;
        alu_pkg::word_t    imm;
        logic              force_pass_x;
        logic              force_x_zero;
        logic              exp_illegal;
        alu_pkg::word_t    exp_result;
        logic              exp_carry;
        logic              exp_zero;
    } row_t;

    localparam int MAX_ROWS     = 32;
    localparam int RESET_CYCLES = 16;

    logic              clk;
    logic              arst_n;
    logic              instr_valid;
    alu_pkg::alu_op_t  op_code;
    alu_pkg::reg_sel_t x_sel;
    alu_pkg::reg_sel_t y_sel;
    alu_pkg::reg_sel_t dst_sel;
    logic              use_imm;
    alu_pkg::word_t    imm;
    logic              force_pass_x;
    logic              force_x_zero;
    alu_pkg::word_t    result;
    logic              result_valid;
    logic              flag_cout;
    logic              flag_zero;
    logic              illegal_op;

    row_t rows [MAX_ROWS];
    int   n_rows = 0;
    int   cur_row;
    // row numbers travel with the issue strobe so the monitor knows what is due
    logic pipe_v [2];
    int   pipe_row [2];
    int   n_checked = 0;
    int   n_failed = 0;
    int   n_errors = 0;
    int   cycles = 0;
    int   cycle_limit;

    alu_datapath alu_datapath_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .op_code      (op_code),
        .x_sel        (x_sel),
        .y_sel        (y_sel),
        .dst_sel      (dst_sel),
        .use_imm      (use_imm),
        .imm          (imm),
        .force_pass_x (force_pass_x),
        .force_x_zero (force_x_zero),
        .result       (result),
        .result_valid (result_valid),
        .flag_cout    (flag_cout),
        .flag_zero    (flag_zero),
        .illegal_op   (illegal_op)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_row(input alu_pkg::alu_op_t op, input int xs, input int ys,
                           input int ds, input logic ui, input alu_pkg::word_t iv,
                           input logic fpx, input logic fxz, input logic ill,
                           input alu_pkg::word_t res, input logic c, input logic z);
        row_t r;
        r = {op, xs[1:0], ys[1:0], ds[1:0], ui, iv, fpx, fxz, ill, res, c, z};
        rows[n_rows] = r;
        n_rows++;
    endtask

    // each row lists op, x, y, dst, use_imm, imm, pass_x, x_zero, illegal, result, carry, zero
    // registers start at zero and every row sees the writes of the rows above it
    task automatic fill_table();
        // load all four registers, only the zero immediate sets the zero flag
        add_row(alu_pkg::OP_B, 0, 0, 0, 1, 8'd200, 0, 0, 0, 8'd200, 0, 0);
        add_row(alu_pkg::OP_B, 0, 0, 1, 1, 8'd100, 0, 0, 0, 8'd100, 0, 0);
        add_row(alu_pkg::OP_B, 0, 0, 2, 1, 8'd0, 0, 0, 0, 8'd0, 0, 1);
        add_row(alu_pkg::OP_B, 0, 0, 3, 1, 8'd5, 0, 0, 0, 8'd5, 0, 0);
        // 200 + 100 wraps to 44, then 44 + 5 + carry depends on it at once
        add_row(alu_pkg::OP_A_PLUS_B, 0, 1, 2, 0, 8'd0, 0, 0, 0, 8'd44, 1, 0);
        add_row(alu_pkg::OP_A_PLUS_B, 2, 3, 2, 0, 8'd0, 0, 0, 0, 8'd50, 0, 0);
        // 5 - 100 borrows to 161, then 50 - 161 - 1 borrows to 144
        add_row(alu_pkg::OP_A_MINUS_B, 3, 1, 3, 0, 8'd0, 0, 0, 0, 8'd161, 1, 0);
        add_row(alu_pkg::OP_B_MINUS_A, 3, 2, 3, 0, 8'd0, 0, 0, 0, 8'd144, 1, 0);
        // unary operations wrap in eight bits and keep the carry at one
        add_row(alu_pkg::OP_MINUS_A, 1, 0, 1, 0, 8'd0, 0, 0, 0, 8'd156, 1, 0);
        add_row(alu_pkg::OP_A_MINUS_1, 2, 0, 2, 0, 8'd0, 0, 0, 0, 8'd49, 1, 0);
        add_row(alu_pkg::OP_B_PLUS_1, 0, 0, 2, 1, 8'd255, 0, 0, 0, 8'd0, 1, 1);
        add_row(alu_pkg::OP_B_MINUS_1, 0, 0, 2, 1, 8'd0, 0, 0, 0, 8'd255, 1, 0);
        add_row(alu_pkg::OP_A_PLUS_1, 0, 0, 0, 0, 8'd0, 0, 0, 0, 8'd201, 1, 0);
        add_row(alu_pkg::OP_MINUS_B, 0, 3, 1, 0, 8'd0, 0, 0, 0, 8'd112, 1, 0);
        // 0x90 and 0x70 give 0x10, 0xc9 or 0x36 gives 0xff
        add_row(alu_pkg::OP_A_AND_B, 3, 1, 3, 0, 8'd0, 0, 0, 0, 8'd16, 1, 0);
        add_row(alu_pkg::OP_A_OR_B, 0, 0, 1, 1, 8'h36, 0, 0, 0, 8'd255, 1, 0);
        add_row(alu_pkg::OP_A_AND_B, 3, 0, 3, 1, 8'h0f, 0, 0, 0, 8'd0, 1, 1);
        add_row(alu_pkg::OP_0, 0, 0, 2, 0, 8'd0, 0, 0, 0, 8'd0, 1, 1);
        // 201 - 100 - 1 leaves no borrow
        add_row(alu_pkg::OP_A_MINUS_B, 0, 0, 0, 1, 8'd100, 0, 0, 0, 8'd100, 0, 0);
        // pass x wins over a logic code and over an illegal one
        add_row(alu_pkg::OP_A_AND_B, 1, 0, 2, 0, 8'd0, 1, 0, 0, 8'd255, 0, 0);
        add_row(5'd12, 0, 0, 3, 0, 8'd0, 1, 0, 0, 8'd100, 0, 0);
        add_row(alu_pkg::OP_A_PLUS_B, 2, 0, 1, 1, 8'd1, 0, 0, 0, 8'd0, 1, 1);
        // the illegal code aimed at r2 leaves 255 there for the read right after
        add_row(5'd31, 0, 0, 2, 1, 8'd99, 0, 0, 1, 8'd0, 1, 1);
        add_row(alu_pkg::OP_A, 2, 0, 2, 0, 8'd0, 0, 0, 0, 8'd255, 1, 0);
        // x held at zero turns the add into 20 plus carry
        add_row(alu_pkg::OP_A_PLUS_B, 0, 0, 1, 1, 8'd20, 0, 1, 0, 8'd21, 0, 0);
        add_row(5'd12, 0, 0, 0, 1, 8'd7, 0, 0, 1, 8'd0, 0, 0);
        add_row(alu_pkg::OP_A, 0, 0, 0, 0, 8'd0, 0, 0, 0, 8'd100, 0, 0);
    endtask

    task automatic check_row(input int k);
        row_t r;
        int   errs_before;
        r = rows[k];
        errs_before = n_errors;
        if (r.exp_illegal) begin
            if (!illegal_op) begin
                $display("%0t: row %0d expected an illegal_op pulse, none came", $time, k);
                n_errors++;
            end
            if (result_valid) begin
                $display("%0t: row %0d raised result_valid for an illegal code", $time, k);
                n_errors++;
            end
        end else begin
            if (!result_valid) begin
                $display("%0t: row %0d expected a result_valid pulse, none came", $time, k);
                n_errors++;
            end
            if (illegal_op) begin
                $display("%0t: row %0d raised illegal_op for a legal code", $time, k);
                n_errors++;
            end
            if (result !== r.exp_result) begin
                $display("** Error at %0t: result expected %0d actual %0d",
                         $time, r.exp_result, result);
                n_errors++;
            end
        end
        if (flag_cout !== r.exp_carry) begin
            $display("** Error at %0t: flag_cout expected %0b actual %0b",
                     $time, r.exp_carry, flag_cout);
            n_errors++;
        end
        if (flag_zero !== r.exp_zero) begin
            $display("** Error at %0t: flag_zero expected %0b actual %0b",
                     $time, r.exp_zero, flag_zero);
            n_errors++;
        end
        if (n_errors != errs_before) begin
            n_failed++;
        end
        $display("row %0d op %0d: %s", k, r.op, (n_errors == errs_before) ? "pass" : "fail");
        n_checked++;
    endtask

    // sampled on the same edge as the DUT, so the row lines up with its issue
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pipe_v[0] <= 1'b0;
            pipe_v[1] <= 1'b0;
        end else begin
            pipe_v[0]   <= instr_valid;
            pipe_row[0] <= cur_row;
            pipe_v[1]   <= pipe_v[0];
            pipe_row[1] <= pipe_row[0];
        end
    end

    // outputs settle after the rising edge, the falling edge is a quiet point
    always @(negedge clk) begin
        if (arst_n) begin
            if (pipe_v[1]) begin
                check_row(pipe_row[1]);
            end else if (result_valid || illegal_op) begin
                $display("%0t: result_valid or illegal_op pulsed with nothing issued", $time);
                n_errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d rows checked",
                     cycles, n_checked, n_rows);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        op_code      = '0;
        x_sel        = '0;
        y_sel        = '0;
        dst_sel      = '0;
        use_imm      = 1'b0;
        imm          = '0;
        force_pass_x = 1'b0;
        force_x_zero = 1'b0;
        cur_row      = 0;
        fill_table();
        cycle_limit = RESET_CYCLES + 2 * n_rows + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        // one row per cycle, so up to two instructions are in flight
        for (int k = 0; k < n_rows; k++) begin
            instr_valid  <= 1'b1;
            op_code      <= rows[k].op;
            x_sel        <= rows[k].x_sel;
            y_sel        <= rows[k].y_sel;
            dst_sel      <= rows[k].dst_sel;
            use_imm      <= rows[k].use_imm;
            imm          <= rows[k].imm;
            force_pass_x <= rows[k].force_pass_x;
            force_x_zero <= rows[k].force_x_zero;
            cur_row      <= k;
            @(posedge clk);
        end
        instr_valid <= 1'b0;
        wait (n_checked == n_rows);
        @(negedge clk);
        #1;
        $display("%0d rows checked, %0d rows failed, %0d errors, %0d assertion failures",
                 n_checked, n_failed, n_errors,
                 alu_datapath_i.alu_datapath_asserts_i.fail_count);
        if (n_errors == 0 && alu_datapath_i.alu_datapath_asserts_i.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : alu_datapath_tb

`default_nettype wire

/* verification/alu_datapath_asserts.sv */
`default_nettype none
`timescale 1ns/10ps

module alu_datapath_asserts (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic instr_valid,
    input wire logic result_valid,
    input wire logic illegal_op,
    input wire logic flag_cout,
    input wire logic wb_valid,
    input wire logic wb_write_carry
);

    // number of assertion failures seen so far
    int fail_count = 0;

    // an instruction ends as either a result or an illegal pulse, never both
    a_one_outcome: assert property (@(posedge clk) disable iff (!arst_n)
        !(result_valid && illegal_op))
        else begin
            fail_count++;
            $error("result_valid and illegal_op high in the same cycle");
        end

    // every issued instruction comes out exactly two cycles later
    a_issue_to_outcome: assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid |-> ##2 (result_valid || illegal_op))
        else begin
            fail_count++;
            $error("no result_valid or illegal_op two cycles after instr_valid");
        end

    // and nothing comes out that was not issued two cycles before
    a_outcome_has_issue: assert property (@(posedge clk) disable iff (!arst_n)
        (result_valid || illegal_op) |-> $past(instr_valid, 2))
        else begin
            fail_count++;
            $error("result_valid or illegal_op without instr_valid two cycles before");
        end

    // the carry register moves only on a valid add or subtract write
    a_carry_kept: assert property (@(posedge clk) disable iff (!arst_n)
        !(wb_valid && wb_write_carry) |=> $stable(flag_cout))
        else begin
            fail_count++;
            $error("carry changed on a cycle with no carry write");
        end

endmodule : alu_datapath_asserts

// the writeback side of the result interface tells when carry may change
bind alu_datapath alu_datapath_asserts alu_datapath_asserts_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .instr_valid    (instr_valid),
    .result_valid   (result_valid),
    .illegal_op     (illegal_op),
    .flag_cout      (flag_cout),
    .wb_valid       (alu_result_if_i.valid),
    .wb_write_carry (alu_result_if_i.write_carry)
);

`default_nettype wire

/* logic/alu_datapath.sv */
`default_nettype none
`timescale 1ns/10ps

module alu_datapath (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              instr_valid,
    input  alu_pkg::alu_op_t  op_code,
    input  alu_pkg::reg_sel_t x_sel,
    input  alu_pkg::reg_sel_t y_sel,
    input  alu_pkg::reg_sel_t dst_sel,
    input  logic              use_imm,
    input  alu_pkg::word_t    imm,
    input  logic              force_pass_x,
    input  logic              force_x_zero,
    output alu_pkg::word_t    result,
    output logic              result_valid,
    output logic              flag_cout,
    output logic              flag_zero,
    output logic              illegal_op
);

    // links between decode, execute and the register file
    alu_ctrl_if   alu_ctrl_if_i ();
    reg_read_if   reg_read_if_i ();
    alu_result_if alu_result_if_i ();

    // first stage registers the instruction and resolves the operation
    control_decode control_decode_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .op_code      (op_code),
        .x_sel        (x_sel),
        .y_sel        (y_sel),
        .dst_sel      (dst_sel),
        .use_imm      (use_imm),
        .imm          (imm),
        .force_pass_x (force_pass_x),
        .force_x_zero (force_x_zero),
        .ctrl         (alu_ctrl_if_i.decode)
    );

    // the carry flag out of writeback feeds straight back as carry in
    alu alu_i (
        .ctrl     (alu_ctrl_if_i.execute),
        .rd       (reg_read_if_i.execute),
        .res      (alu_result_if_i.execute),
        .carry_in (flag_cout)
    );

    reg_writeback reg_writeback_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .rd           (reg_read_if_i.regs),
        .res          (alu_result_if_i.writeback),
        .carry        (flag_cout),
        .result       (result),
        .result_valid (result_valid),
        .flag_zero    (flag_zero),
        .illegal_op   (illegal_op)
    );

endmodule : alu_datapath

`default_nettype wire

/* logic/reg_writeback.sv */
`default_nettype none
`timescale 1ns/10ps

module reg_writeback (
    input  logic           clk,
    input  logic           arst_n,
    reg_read_if.regs       rd,
    alu_result_if.writeback res,
    output logic           carry,
    output alu_pkg::word_t result,
    output logic           result_valid,
    output logic           flag_zero,
    output logic           illegal_op
);

    alu_pkg::word_t regs [alu_pkg::NUM_REGS];

    // read ports are combinational so the next instruction sees this write
    assign rd.x_val = regs[rd.x_sel];
    assign rd.y_val = regs[rd.y_sel];

    // register file and flags, all cleared on reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < alu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            carry     <= 1'b0;
            flag_zero <= 1'b0;
        end else if (res.valid) begin
            regs[res.dst_sel] <= res.value;
            flag_zero         <= (res.value == '0);
            // carry only moves for add and subtract, other ops keep it
            if (res.write_carry) begin
                carry <= res.cout;
            end
        end
    end

    // an illegal code only raises its own pulse and touches no state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            illegal_op   <= 1'b0;
        end else begin
            result_valid <= res.valid;
            illegal_op   <= res.illegal;
        end
    end

    // result output holds the last written value between pulses
    always_ff @(posedge clk) begin
        if (res.valid) begin
            result <= res.value;
        end
    end

endmodule : reg_writeback

`default_nettype wire

/* logic/alu.sv */
`default_nettype none
`timescale 1ns/10ps

module alu (
    alu_ctrl_if.execute   ctrl,
    reg_read_if.execute   rd,
    alu_result_if.execute res,
    input  logic          carry_in
);

    alu_pkg::word_t      x_op;
    alu_pkg::word_t      y_op;
    alu_pkg::word_carry_t x_ext;
    alu_pkg::word_carry_t y_ext;
    alu_pkg::word_carry_t cin_ext;
    alu_pkg::word_carry_t sum;

    // register addresses go straight out, the values come back this cycle
    assign rd.x_sel = ctrl.x_sel;
    assign rd.y_sel = ctrl.y_sel;

    // x can be held at zero, which turns x+y into a plain y plus carry
    assign x_op = ctrl.zero_x ? '0 : rd.x_val;

    // y is either the second register or the immediate from the instruction
    assign y_op = ctrl.use_imm ? ctrl.imm : rd.y_val;

    // zero extended so that bit 8 of every result is the carry or borrow
    assign x_ext   = {1'b0, x_op};
    assign y_ext   = {1'b0, y_op};
    assign cin_ext = {{alu_pkg::WORD_W{1'b0}}, carry_in};

    always_comb begin
        case (ctrl.op)
            alu_pkg::OP_A: begin
                sum = x_ext;
            end
            alu_pkg::OP_B: begin
                sum = y_ext;
            end
            alu_pkg::OP_0: begin
                sum = '0;
            end
            // negation is two's complement in the low eight bits
            alu_pkg::OP_MINUS_A: begin
                sum = '0 - x_ext;
            end
            alu_pkg::OP_MINUS_B: begin
                sum = '0 - y_ext;
            end
            alu_pkg::OP_A_PLUS_1: begin
                sum = x_ext + 9'd1;
            end
            alu_pkg::OP_B_PLUS_1: begin
                sum = y_ext + 9'd1;
            end
            alu_pkg::OP_A_MINUS_1: begin
                sum = x_ext - 9'd1;
            end
            alu_pkg::OP_B_MINUS_1: begin
                sum = y_ext - 9'd1;
            end
            // the carry flag enters only these three and chains multi-byte math
            alu_pkg::OP_A_PLUS_B: begin
                sum = x_ext + y_ext + cin_ext;
            end
            // a borrow wraps the top bit to one
            alu_pkg::OP_A_MINUS_B: begin
                sum = x_ext - y_ext - cin_ext;
            end
            alu_pkg::OP_B_MINUS_A: begin
                sum = y_ext - x_ext - cin_ext;
            end
            alu_pkg::OP_A_AND_B: begin
                sum = x_ext & y_ext;
            end
            alu_pkg::OP_A_OR_B: begin
                sum = x_ext | y_ext;
            end
            // illegal codes never get written, so any known value will do
            default: begin
                sum = '0;
            end
        endcase
    end

    assign res.value = sum[alu_pkg::WORD_W-1:0];
    assign res.cout  = sum[alu_pkg::WORD_W];

    // qualifiers ride along unchanged, the stage adds no latency
    assign res.valid       = ctrl.valid;
    assign res.illegal     = ctrl.illegal;
    assign res.dst_sel     = ctrl.dst_sel;
    assign res.write_carry = ctrl.write_carry;

endmodule : alu

`default_nettype wire

/* logic/control_decode.sv */
`default_nettype none
`timescale 1ns/10ps

module control_decode (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              instr_valid,
    input  alu_pkg::alu_op_t  op_code,
    input  alu_pkg::reg_sel_t x_sel,
    input  alu_pkg::reg_sel_t y_sel,
    input  alu_pkg::reg_sel_t dst_sel,
    input  logic              use_imm,
    input  alu_pkg::word_t    imm,
    input  logic              force_pass_x,
    input  logic              force_x_zero,
    alu_ctrl_if.decode        ctrl
);

    alu_pkg::alu_op_t eff_op;
    logic             op_legal;
    logic             op_carry;

    // forcing pass-x overrides whatever code came with the instruction
    assign eff_op = force_pass_x ? alu_pkg::OP_A : op_code;

    // classify the effective code before it is registered
    always_comb begin
        op_legal = 1'b1;
        op_carry = 1'b0;
        case (eff_op)
            alu_pkg::OP_A, alu_pkg::OP_B, alu_pkg::OP_0,
            alu_pkg::OP_MINUS_A, alu_pkg::OP_MINUS_B,
            alu_pkg::OP_A_PLUS_1, alu_pkg::OP_B_PLUS_1,
            alu_pkg::OP_A_MINUS_1, alu_pkg::OP_B_MINUS_1,
            alu_pkg::OP_A_AND_B, alu_pkg::OP_A_OR_B: begin
                op_legal = 1'b1;
            end
            // only the add and subtract group updates the carry flag
            alu_pkg::OP_A_PLUS_B, alu_pkg::OP_A_MINUS_B, alu_pkg::OP_B_MINUS_A: begin
                op_carry = 1'b1;
            end
            default: begin
                op_legal = 1'b0;
            end
        endcase
    end

    // the strobe is split so that exactly one pulse leaves for each issue
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl.valid   <= 1'b0;
            ctrl.illegal <= 1'b0;
        end else begin
            ctrl.valid   <= instr_valid & op_legal;
            ctrl.illegal <= instr_valid & ~op_legal;
        end
    end

    // instruction fields, qualified downstream by the pulses above
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ctrl.op          <= eff_op;
            ctrl.zero_x      <= force_x_zero;
            ctrl.x_sel       <= x_sel;
            ctrl.y_sel       <= y_sel;
            ctrl.use_imm     <= use_imm;
            ctrl.imm         <= imm;
            ctrl.dst_sel     <= dst_sel;
            ctrl.write_carry <= op_carry;
        end
    end

endmodule : control_decode

`default_nettype wire

/* logic/alu_ifs.sv */
`default_nettype none
`timescale 1ns/10ps

// decoded instruction going from the decode stage into the execute stage
interface alu_ctrl_if;
    // one of these two pulses for every issued instruction, never both
    logic              valid;
    logic              illegal;
    // effective operation after any forcing has been applied
    alu_pkg::alu_op_t  op;
    logic              zero_x;
    alu_pkg::reg_sel_t x_sel;
    alu_pkg::reg_sel_t y_sel;
    logic              use_imm;
    alu_pkg::word_t    imm;
    alu_pkg::reg_sel_t dst_sel;
    // set only for the operations that produce a carry or borrow
    logic              write_carry;

    modport decode (
        output valid, illegal, op, zero_x, x_sel, y_sel,
        output use_imm, imm, dst_sel, write_carry
    );

    modport execute (
        input valid, illegal, op, zero_x, x_sel, y_sel,
        input use_imm, imm, dst_sel, write_carry
    );
endinterface : alu_ctrl_if

// two combinational read ports into the register file
interface reg_read_if;
    alu_pkg::reg_sel_t x_sel;
    alu_pkg::reg_sel_t y_sel;
    alu_pkg::word_t    x_val;
    alu_pkg::word_t    y_val;

    // the execute stage asks, the register file answers in the same cycle
    modport execute (output x_sel, y_sel, input x_val, y_val);
    modport regs (input x_sel, y_sel, output x_val, y_val);
endinterface : reg_read_if

// result of the execute stage on its way into writeback
interface alu_result_if;
    logic              valid;
    logic              illegal;
    alu_pkg::word_t    value;
    // bit above the word, only meaningful when write_carry is set
    logic              cout;
    alu_pkg::reg_sel_t dst_sel;
    logic              write_carry;

    modport execute (output valid, illegal, value, cout, dst_sel, write_carry);
    modport writeback (input valid, illegal, value, cout, dst_sel, write_carry);
endinterface : alu_result_if

`default_nettype wire

/* logic/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    // width of a data word and of a word extended with its carry bit
    localparam int WORD_W = 8;

    // a plain data word used for operands, immediates, results and registers
    typedef logic [WORD_W-1:0] word_t;

    // a word with one extra bit on top that holds the carry or borrow
    typedef logic [WORD_W:0] word_carry_t;

    // index into the general register file
    typedef logic [1:0] reg_sel_t;

    // operation code as it arrives from the instruction
    typedef logic [4:0] alu_op_t;

    // the register file holds one register per reg_sel_t value
    localparam int NUM_REGS = 4;

    // pass and constant operations
    localparam alu_op_t OP_A         = 5'd0;
    localparam alu_op_t OP_B         = 5'd1;
    localparam alu_op_t OP_0         = 5'd2;
    localparam alu_op_t OP_MINUS_A   = 5'd3;
    localparam alu_op_t OP_MINUS_B   = 5'd4;

    // increment and decrement of either operand
    localparam alu_op_t OP_A_PLUS_1  = 5'd5;
    localparam alu_op_t OP_B_PLUS_1  = 5'd6;
    localparam alu_op_t OP_A_MINUS_1 = 5'd7;
    localparam alu_op_t OP_B_MINUS_1 = 5'd8;

    // these three take the carry flag in and write it back out
    localparam alu_op_t OP_A_PLUS_B  = 5'd9;
    localparam alu_op_t OP_A_MINUS_B = 5'd10;
    localparam alu_op_t OP_B_MINUS_A = 5'd11;

    // bitwise logic, the codes sit in the fourth column of the op map
    localparam alu_op_t OP_A_AND_B   = 5'd25;
    localparam alu_op_t OP_A_OR_B    = 5'd26;

endpackage : alu_pkg

`default_nettype wire
